// ==== Makefile ====
VERILATOR  ?= verilator
TOP        = tb_host_mem
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = CHECKS FAILED
PASS_MSG   = ALL CHECKS PASSED
FLAGS      = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/host_mem_pkg.sv ====
package host_mem_pkg;

   // ----------------------------------------------------------
   // bus and memory geometry
   // ----------------------------------------------------------
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 64;
   localparam int BEAT_BYTES = DATA_W / 8;
   localparam int BEAT_SHIFT = 3;           // log2 of BEAT_BYTES
   localparam int ID_W       = 5;
   localparam int LEN_W      = 8;           // beats minus one

   localparam int MEM_WORDS  = 256;
   localparam int MEM_IDX_W  = 8;

   // queue depths
   localparam int CMD_DEPTH  = 4;
   localparam int BEAT_DEPTH = 8;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // read sequencer states
   localparam logic [1:0] RD_IDLE    = 2'd0;
   localparam logic [1:0] RD_ISSUE   = 2'd1;
   localparam logic [1:0] RD_PRESENT = 2'd2;

   // one beat, as a word or as byte lanes
   typedef union packed {
      logic [DATA_W-1:0]          word;
      logic [BEAT_BYTES-1:0][7:0] bytes;
   } beat_u;

endpackage

// ==== common/mem_wr_if.sv ====
`timescale 1ns/1ps

interface mem_wr_if;

   logic                                en;
   logic [host_mem_pkg::MEM_IDX_W-1:0]  idx;
   host_mem_pkg::beat_u                 data;
   logic [host_mem_pkg::BEAT_BYTES-1:0] strb;   // one bit per byte lane

   modport engine (
      output en, idx, data, strb
   );

   // taken on every edge with en high
   modport ram (
      input en, idx, data, strb
   );

endinterface

// ==== files.f ====
common/host_mem_pkg.sv
common/mem_wr_if.sv
src/cmd_fifo.sv
src/host_mem_ram.sv
pcim_write/pcim_write_engine.sv
pcim_read/pcim_read_engine.sv
src/host_mem_top.sv
tests/host_mem_checker.sv
tests/host_mem_assert.sv
tests/tb_host_mem.sv

// ==== pcim_read/pcim_read_engine.sv ====
`timescale 1ns/1ps

module pcim_read_engine (
   input  logic                               clk_out,
   input  logic                               sync_rst_n,
   // read address
   input  logic [host_mem_pkg::ID_W-1:0]      arid_i,
   input  logic [host_mem_pkg::ADDR_W-1:0]    araddr_i,
   input  logic [host_mem_pkg::LEN_W-1:0]     arlen_i,
   input  logic                               arvalid_i,
   output logic                               arready_o,
   // read data
   output logic [host_mem_pkg::ID_W-1:0]      rid_o,
   output logic [host_mem_pkg::DATA_W-1:0]    rdata_o,
   output logic [1:0]                         rresp_o,
   output logic                               rlast_o,
   output logic                               rvalid_o,
   input  logic                               rready_i,
   // memory read port
   output logic                               rd_en_o,
   output logic [host_mem_pkg::MEM_IDX_W-1:0] rd_idx_o,
   input  host_mem_pkg::beat_u                rd_data_i
);

   logic [host_mem_pkg::ID_W-1:0]      cmd_id;
   logic [host_mem_pkg::MEM_IDX_W-1:0] cmd_idx;
   logic [host_mem_pkg::LEN_W-1:0]     cmd_len;
   logic                               cmd_full;
   logic                               cmd_empty;
   logic                               cmd_pop;
   logic [1:0]                         state;
   logic [host_mem_pkg::LEN_W-1:0]     beat_cnt;
   logic [host_mem_pkg::MEM_IDX_W-1:0] idx_q;
   logic                               last_beat;

   cmd_fifo #(
      .WIDTH (host_mem_pkg::ID_W + host_mem_pkg::MEM_IDX_W + host_mem_pkg::LEN_W),
      .DEPTH (host_mem_pkg::CMD_DEPTH)
   ) cmd_q_i (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .push_i      (arvalid_i),
      .push_data_i ({arid_i, araddr_i[host_mem_pkg::BEAT_SHIFT +: host_mem_pkg::MEM_IDX_W],
                     arlen_i}),
      .full_o      (cmd_full),
      .pop_i       (cmd_pop),
      .pop_data_o  ({cmd_id, cmd_idx, cmd_len}),
      .empty_o     (cmd_empty)
   );

   assign arready_o = ~cmd_full;
   assign last_beat = (beat_cnt == cmd_len);

   // ----------------------------------------------------------
   // beat sequencer
   // ----------------------------------------------------------
   assign rd_en_o  = (state == host_mem_pkg::RD_ISSUE);
   assign rd_idx_o = idx_q;
   assign rvalid_o = (state == host_mem_pkg::RD_PRESENT);
   assign rlast_o  = rvalid_o & last_beat;
   assign rid_o    = cmd_id;               // head stays until the burst ends
   assign rdata_o  = rd_data_i.word;       // held by the ram register
   assign rresp_o  = host_mem_pkg::RESP_OKAY;
   assign cmd_pop  = rlast_o & rready_i;

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state    <= host_mem_pkg::RD_IDLE;
         beat_cnt <= '0;
         idx_q    <= '0;
      end else begin
         case (state)
            host_mem_pkg::RD_IDLE: begin
               if (!cmd_empty) begin
                  idx_q    <= cmd_idx;
                  beat_cnt <= '0;
                  state    <= host_mem_pkg::RD_ISSUE;
               end
            end
            host_mem_pkg::RD_ISSUE: begin
               state <= host_mem_pkg::RD_PRESENT;   // data lands next edge
            end
            host_mem_pkg::RD_PRESENT: begin
               if (rready_i) begin
                  if (last_beat) begin
                     state <= host_mem_pkg::RD_IDLE;
                  end else begin
                     beat_cnt <= beat_cnt + 1'b1;
                     idx_q    <= idx_q + 1'b1;   // wraps at memory depth
                     state    <= host_mem_pkg::RD_ISSUE;
                  end
               end
            end
            default: state <= host_mem_pkg::RD_IDLE;
         endcase
      end
   end

endmodule

// ==== pcim_write/pcim_write_engine.sv ====
`timescale 1ns/1ps

module pcim_write_engine (
   input  logic                                clk_out,
   input  logic                                sync_rst_n,
   // write address
   input  logic [host_mem_pkg::ID_W-1:0]       awid_i,
   input  logic [host_mem_pkg::ADDR_W-1:0]     awaddr_i,
   input  logic                                awvalid_i,
   output logic                                awready_o,
   // write data
   input  logic [host_mem_pkg::DATA_W-1:0]     wdata_i,
   input  logic [host_mem_pkg::BEAT_BYTES-1:0] wstrb_i,
   input  logic                                wlast_i,
   input  logic                                wvalid_i,
   output logic                                wready_o,
   // write response
   output logic [host_mem_pkg::ID_W-1:0]       bid_o,
   output logic [1:0]                          bresp_o,
   output logic                                bvalid_o,
   input  logic                                bready_i,
   mem_wr_if.engine                            mem
);

   logic [host_mem_pkg::ID_W-1:0]       cmd_id;
   logic [host_mem_pkg::MEM_IDX_W-1:0]  cmd_idx;
   logic                                cmd_full;
   logic                                cmd_empty;
   logic                                cmd_pop;
   logic [host_mem_pkg::DATA_W-1:0]     beat_data;
   logic [host_mem_pkg::BEAT_BYTES-1:0] beat_strb;
   logic                                beat_last;
   logic                                beat_full;
   logic                                beat_empty;
   logic                                beat_fire;
   logic                                first_beat;
   logic [host_mem_pkg::MEM_IDX_W-1:0]  next_idx;
   logic [host_mem_pkg::MEM_IDX_W-1:0]  beat_idx;

   // ----------------------------------------------------------
   // command and beat queues
   // ----------------------------------------------------------
   cmd_fifo #(
      .WIDTH (host_mem_pkg::ID_W + host_mem_pkg::MEM_IDX_W),
      .DEPTH (host_mem_pkg::CMD_DEPTH)
   ) cmd_q_i (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .push_i      (awvalid_i),
      .push_data_i ({awid_i, awaddr_i[host_mem_pkg::BEAT_SHIFT +: host_mem_pkg::MEM_IDX_W]}),
      .full_o      (cmd_full),
      .pop_i       (cmd_pop),
      .pop_data_o  ({cmd_id, cmd_idx}),
      .empty_o     (cmd_empty)
   );

   cmd_fifo #(
      .WIDTH (host_mem_pkg::DATA_W + host_mem_pkg::BEAT_BYTES + 1),
      .DEPTH (host_mem_pkg::BEAT_DEPTH)
   ) beat_q_i (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .push_i      (wvalid_i),
      .push_data_i ({wdata_i, wstrb_i, wlast_i}),
      .full_o      (beat_full),
      .pop_i       (beat_fire),
      .pop_data_o  ({beat_data, beat_strb, beat_last}),
      .empty_o     (beat_empty)
   );

   assign awready_o = ~cmd_full;
   assign wready_o  = ~beat_full;

   // pending response holds off further beats
   assign beat_fire = ~cmd_empty & ~beat_empty & ~bvalid_o;
   assign beat_idx  = first_beat ? cmd_idx : next_idx;
   assign cmd_pop   = bvalid_o & bready_i;   // command retires with its response

   // ----------------------------------------------------------
   // memory write
   // ----------------------------------------------------------
   assign mem.en        = beat_fire;
   assign mem.idx       = beat_idx;
   assign mem.data.word = beat_data;
   assign mem.strb      = beat_strb;

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         first_beat <= 1'b1;
         next_idx   <= '0;
         bvalid_o   <= 1'b0;
      end else begin
         if (beat_fire) begin
            next_idx   <= beat_idx + 1'b1;   // wraps at memory depth
            first_beat <= beat_last;
         end
         if (beat_fire && beat_last) begin
            bvalid_o <= 1'b1;
         end else if (bready_i) begin
            bvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_out) begin
      if (beat_fire && beat_last) begin
         bid_o <= cmd_id;
      end
   end

   assign bresp_o = host_mem_pkg::RESP_OKAY;

endmodule

// ==== src/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk_out,
   input  logic             sync_rst_n,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   output logic             full_o,
   input  logic             pop_i,
   output logic [WIDTH-1:0] pop_data_o,
   output logic             empty_o
);

   logic [WIDTH-1:0]         mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH):0]   count;
   logic                     do_push;
   logic                     do_pop;

   assign full_o     = (count == ($clog2(DEPTH)+1)'(DEPTH));
   assign empty_o    = (count == '0);
   assign do_push    = push_i & ~full_o;
   assign do_pop     = pop_i & ~empty_o;
   assign pop_data_o = mem[rd_ptr];   // head shows without a pop

   always_ff @(posedge clk_out) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none or both
         endcase
      end
   end

endmodule

// ==== src/host_mem_ram.sv ====
`timescale 1ns/1ps

module host_mem_ram (
   input  logic                               clk_out,
   mem_wr_if.ram                              wr,
   input  logic                               rd_en_i,
   input  logic [host_mem_pkg::MEM_IDX_W-1:0] rd_idx_i,
   output host_mem_pkg::beat_u                rd_data_o
);

   host_mem_pkg::beat_u mem [host_mem_pkg::MEM_WORDS];

   // ----------------------------------------------------------
   // byte-enabled write port
   // ----------------------------------------------------------
   always_ff @(posedge clk_out) begin
      if (wr.en) begin
         for (int b = 0; b < host_mem_pkg::BEAT_BYTES; b++) begin
            if (wr.strb[b]) begin
               mem[wr.idx].bytes[b] <= wr.data.bytes[b];
            end
         end
      end
   end

   // ----------------------------------------------------------
   // registered read port
   // ----------------------------------------------------------
   // same-index write in the same cycle returns old data
   always_ff @(posedge clk_out) begin
      if (rd_en_i) begin
         rd_data_o.word <= mem[rd_idx_i].word;
      end
   end

endmodule

// ==== src/host_mem_top.sv ====
`timescale 1ns/1ps

module host_mem_top (
   input  logic                                clk_out,
   input  logic                                sync_rst_n,
   input  logic [host_mem_pkg::ID_W-1:0]       pcim_awid_i,
   input  logic [host_mem_pkg::ADDR_W-1:0]     pcim_awaddr_i,
   input  logic                                pcim_awvalid_i,
   output logic                                pcim_awready_o,
   input  logic [host_mem_pkg::DATA_W-1:0]     pcim_wdata_i,
   input  logic [host_mem_pkg::BEAT_BYTES-1:0] pcim_wstrb_i,
   input  logic                                pcim_wlast_i,
   input  logic                                pcim_wvalid_i,
   output logic                                pcim_wready_o,
   output logic [host_mem_pkg::ID_W-1:0]       pcim_bid_o,
   output logic [1:0]                          pcim_bresp_o,
   output logic                                pcim_bvalid_o,
   input  logic                                pcim_bready_i,
   input  logic [host_mem_pkg::ID_W-1:0]       pcim_arid_i,
   input  logic [host_mem_pkg::ADDR_W-1:0]     pcim_araddr_i,
   input  logic [host_mem_pkg::LEN_W-1:0]      pcim_arlen_i,
   input  logic                                pcim_arvalid_i,
   output logic                                pcim_arready_o,
   output logic [host_mem_pkg::ID_W-1:0]       pcim_rid_o,
   output logic [host_mem_pkg::DATA_W-1:0]     pcim_rdata_o,
   output logic [1:0]                          pcim_rresp_o,
   output logic                                pcim_rlast_o,
   output logic                                pcim_rvalid_o,
   input  logic                                pcim_rready_i
);

   logic                               rd_en;
   logic [host_mem_pkg::MEM_IDX_W-1:0] rd_idx;
   host_mem_pkg::beat_u                rd_data;

   mem_wr_if mem_wr ();

   pcim_write_engine write_engine_i (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .awid_i     (pcim_awid_i),
      .awaddr_i   (pcim_awaddr_i),
      .awvalid_i  (pcim_awvalid_i),
      .awready_o  (pcim_awready_o),
      .wdata_i    (pcim_wdata_i),
      .wstrb_i    (pcim_wstrb_i),
      .wlast_i    (pcim_wlast_i),
      .wvalid_i   (pcim_wvalid_i),
      .wready_o   (pcim_wready_o),
      .bid_o      (pcim_bid_o),
      .bresp_o    (pcim_bresp_o),
      .bvalid_o   (pcim_bvalid_o),
      .bready_i   (pcim_bready_i),
      .mem        (mem_wr.engine)
   );

   pcim_read_engine read_engine_i (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .arid_i     (pcim_arid_i),
      .araddr_i   (pcim_araddr_i),
      .arlen_i    (pcim_arlen_i),
      .arvalid_i  (pcim_arvalid_i),
      .arready_o  (pcim_arready_o),
      .rid_o      (pcim_rid_o),
      .rdata_o    (pcim_rdata_o),
      .rresp_o    (pcim_rresp_o),
      .rlast_o    (pcim_rlast_o),
      .rvalid_o   (pcim_rvalid_o),
      .rready_i   (pcim_rready_i),
      .rd_en_o    (rd_en),
      .rd_idx_o   (rd_idx),
      .rd_data_i  (rd_data)
   );

   // shared beat store
   host_mem_ram ram_i (
      .clk_out   (clk_out),
      .wr        (mem_wr.ram),
      .rd_en_i   (rd_en),
      .rd_idx_i  (rd_idx),
      .rd_data_o (rd_data)
   );

endmodule

// ==== tests/host_mem_assert.sv ====
`timescale 1ns/1ps

module host_mem_assert (
   input logic        clk_out,
   input logic        sync_rst_n,
   input logic        awvalid_i,
   input logic        awready_i,
   input logic [31:0] awaddr_i,
   input logic        wvalid_i,
   input logic        wready_i,
   input logic        wlast_i,
   input logic        bvalid_i,
   input logic        bready_i,
   input logic [4:0]  bid_i,
   input logic        arready_i,
   input logic        rvalid_i,
   input logic        rready_i,
   input logic        rlast_i,
   input logic [4:0]  rid_i,
   input logic [63:0] rdata_i
);

   int lasts_pending;   // last beats taken, minus responses

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         lasts_pending <= 0;
      end else begin
         lasts_pending <= lasts_pending + int'(wvalid_i && wready_i && wlast_i)
                          - int'(bvalid_i && bready_i);
      end
   end

   aw_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
      else $error("aw channel dropped before handshake");

   b_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
      else $error("b channel changed before handshake");

   r_hold: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      rvalid_i && !rready_i |=> rvalid_i && $stable({rdata_i, rid_i, rlast_i}))
      else $error("r channel changed before handshake");

   b_after_last: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      $rose(bvalid_i) |-> lasts_pending > 0)
      else $error("response without a last beat");

   no_x: assert property (@(posedge clk_out) disable iff (!sync_rst_n)
      !$isunknown({awready_i, wready_i, bvalid_i, arready_i, rvalid_i, rlast_i}))
      else $error("unknown handshake output");

endmodule

bind host_mem_top host_mem_assert host_mem_assert_i (
   .clk_out    (clk_out),
   .sync_rst_n (sync_rst_n),
   .awvalid_i  (pcim_awvalid_i),
   .awready_i  (pcim_awready_o),
   .awaddr_i   (pcim_awaddr_i),
   .wvalid_i   (pcim_wvalid_i),
   .wready_i   (pcim_wready_o),
   .wlast_i    (pcim_wlast_i),
   .bvalid_i   (pcim_bvalid_o),
   .bready_i   (pcim_bready_i),
   .bid_i      (pcim_bid_o),
   .arready_i  (pcim_arready_o),
   .rvalid_i   (pcim_rvalid_o),
   .rready_i   (pcim_rready_i),
   .rlast_i    (pcim_rlast_o),
   .rid_i      (pcim_rid_o),
   .rdata_i    (pcim_rdata_o)
);

// ==== tests/host_mem_checker.sv ====
`timescale 1ns/1ps

module host_mem_checker (
   input  logic        clk_out,
   input  logic        sync_rst_n,
   input  logic [4:0]  awid_i,
   input  logic [31:0] awaddr_i,
   input  logic        awvalid_i,
   input  logic        awready_i,
   input  logic [63:0] wdata_i,
   input  logic [7:0]  wstrb_i,
   input  logic        wlast_i,
   input  logic        wvalid_i,
   input  logic        wready_i,
   input  logic [4:0]  bid_i,
   input  logic [1:0]  bresp_i,
   input  logic        bvalid_i,
   input  logic        bready_i,
   input  logic [4:0]  arid_i,
   input  logic [31:0] araddr_i,
   input  logic [7:0]  arlen_i,
   input  logic        arvalid_i,
   input  logic        arready_i,
   input  logic [4:0]  rid_i,
   input  logic [63:0] rdata_i,
   input  logic [1:0]  rresp_i,
   input  logic        rlast_i,
   input  logic        rvalid_i,
   input  logic        rready_i,
   output int          error_count_o,
   output int          check_count_o,
   output int          pending_wr_o,
   output int          pending_rd_o,
   output int          ar_stall_o
);

   logic [63:0] model [host_mem_pkg::MEM_WORDS];
   logic [4:0]  aw_id_q[$];
   logic [7:0]  aw_idx_q[$];
   logic [63:0] w_data_q[$];
   logic [7:0]  w_strb_q[$];
   logic        w_last_q[$];
   logic [4:0]  ar_id_q[$];
   logic [7:0]  ar_idx_q[$];
   logic [7:0]  ar_len_q[$];
   int          rd_beat;

   initial begin
      error_count_o = 0;
      check_count_o = 0;
      pending_wr_o  = 0;
      pending_rd_o  = 0;
      ar_stall_o    = 0;
      rd_beat       = 0;
   end

   task automatic mismatch(input string msg);
      error_count_o++;
      $display("Fail at %0t ns: %s", $time, msg);
   endtask

   task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
      check_count_o++;
      if (got !== exp) begin
         mismatch($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   // strobed byte lanes replace the old beat
   function automatic logic [63:0] merge_beat(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
      logic [63:0] res;
      res = old;
      for (int b = 0; b < 8; b++) begin
         if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
      end
      return res;
   endfunction

   // expected read beat, index wraps at memory depth
   function automatic logic [63:0] expected_beat(input logic [7:0] base, input int beat_no);
      return model[8'((int'(base) + beat_no) % host_mem_pkg::MEM_WORDS)];
   endfunction

   // reset values
   initial begin
      @(posedge sync_rst_n);
      @(negedge clk_out);
      compare(64'(bvalid_i), 64'd0, "bvalid after reset");
      compare(64'(rvalid_i), 64'd0, "rvalid after reset");
      compare(64'(rlast_i), 64'd0, "rlast after reset");
      compare(64'({awready_i, wready_i, arready_i}), 64'd7, "ready flags after reset");
   end

   always @(posedge clk_out) begin
      logic [7:0] idx;
      logic       last;
      if (sync_rst_n) begin
         if (!arready_i) ar_stall_o++;
         if (awvalid_i && awready_i) begin
            aw_id_q.push_back(awid_i);
            aw_idx_q.push_back(awaddr_i[10:3]);
         end
         if (wvalid_i && wready_i) begin
            w_data_q.push_back(wdata_i);
            w_strb_q.push_back(wstrb_i);
            w_last_q.push_back(wlast_i);
         end
         // ----------------------------------------------------------
         // write response retires the burst into the model
         // ----------------------------------------------------------
         if (bvalid_i && bready_i) begin
            if (aw_id_q.size() == 0) begin
               mismatch("write response with no command");
            end else begin
               compare(64'(bid_i), 64'(aw_id_q[0]), "bid");
               compare(64'(bresp_i), 64'(host_mem_pkg::RESP_OKAY), "bresp");
               idx  = aw_idx_q.pop_front();
               void'(aw_id_q.pop_front());
               last = 1'b0;
               while (!last && w_data_q.size() != 0) begin
                  model[idx] = merge_beat(model[idx], w_data_q.pop_front(),
                                          w_strb_q.pop_front());
                  last = w_last_q.pop_front();
                  idx  = idx + 8'd1;
               end
               if (!last) mismatch("write response before last beat");
            end
         end
         if (arvalid_i && arready_i) begin
            ar_id_q.push_back(arid_i);
            ar_idx_q.push_back(araddr_i[10:3]);
            ar_len_q.push_back(arlen_i);
         end
         // ----------------------------------------------------------
         // read beats
         // ----------------------------------------------------------
         if (rvalid_i && rready_i) begin
            if (ar_id_q.size() == 0) begin
               mismatch("read data with no command");
            end else begin
               compare(rdata_i, expected_beat(ar_idx_q[0], rd_beat), "rdata");
               compare(64'(rid_i), 64'(ar_id_q[0]), "rid");
               compare(64'(rresp_i), 64'(host_mem_pkg::RESP_OKAY), "rresp");
               last = (rd_beat == int'(ar_len_q[0]));
               compare(64'(rlast_i), 64'(last), "rlast");
               if (last) begin
                  void'(ar_id_q.pop_front());
                  void'(ar_idx_q.pop_front());
                  void'(ar_len_q.pop_front());
                  rd_beat = 0;
               end else begin
                  rd_beat++;
               end
            end
         end
         pending_wr_o = aw_id_q.size();
         pending_rd_o = ar_id_q.size();
      end
   end

endmodule

// ==== tests/tb_host_mem.sv ====
`timescale 1ns/1ps

module tb_host_mem;

   localparam int SEED        = 75415;
   localparam int NUM_RANDOM  = 60;
   localparam int TOTAL_OPS   = 140;   // fill, directed and random
   localparam int MAX_BEATS   = 8;
   localparam int BEAT_BOUND  = 40;    // cycles per beat
   localparam int CLK_NS      = 4;
   localparam int WATCHDOG_NS = TOTAL_OPS * MAX_BEATS * BEAT_BOUND * CLK_NS;

   logic        clk_out = 1'b0;
   logic        sync_rst_n;
   logic [4:0]  pcim_awid_i, pcim_bid_o, pcim_arid_i, pcim_rid_o;
   logic [31:0] pcim_awaddr_i, pcim_araddr_i;
   logic        pcim_awvalid_i, pcim_awready_o, pcim_wlast_i, pcim_wvalid_i, pcim_wready_o;
   logic [63:0] pcim_wdata_i, pcim_rdata_o;
   logic [7:0]  pcim_wstrb_i, pcim_arlen_i;
   logic [1:0]  pcim_bresp_o, pcim_rresp_o;
   logic        pcim_bvalid_o, pcim_bready_i, pcim_arvalid_i, pcim_arready_o;
   logic        pcim_rlast_o, pcim_rvalid_o, pcim_rready_i;
   int          error_count, check_count, pending_wr, pending_rd, ar_stall;
   int          tb_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          mark;
   int          stall_base;
   logic        bp_on = 1'b0;     // random back-pressure
   logic        hold_r = 1'b0;    // rready forced low

   always #(CLK_NS / 2) clk_out = ~clk_out;

   host_mem_top host_mem_top_i (.*);

   host_mem_checker checker_i (
      .clk_out (clk_out), .sync_rst_n (sync_rst_n),
      .awid_i (pcim_awid_i), .awaddr_i (pcim_awaddr_i), .awvalid_i (pcim_awvalid_i),
      .awready_i (pcim_awready_o), .wdata_i (pcim_wdata_i), .wstrb_i (pcim_wstrb_i),
      .wlast_i (pcim_wlast_i), .wvalid_i (pcim_wvalid_i), .wready_i (pcim_wready_o),
      .bid_i (pcim_bid_o), .bresp_i (pcim_bresp_o), .bvalid_i (pcim_bvalid_o),
      .bready_i (pcim_bready_i), .arid_i (pcim_arid_i), .araddr_i (pcim_araddr_i),
      .arlen_i (pcim_arlen_i), .arvalid_i (pcim_arvalid_i), .arready_i (pcim_arready_o),
      .rid_i (pcim_rid_o), .rdata_i (pcim_rdata_o), .rresp_i (pcim_rresp_o),
      .rlast_i (pcim_rlast_o), .rvalid_i (pcim_rvalid_o), .rready_i (pcim_rready_i),
      .error_count_o (error_count), .check_count_o (check_count),
      .pending_wr_o (pending_wr), .pending_rd_o (pending_rd), .ar_stall_o (ar_stall)
   );

   // response-side ready, driven after the edge
   always @(posedge clk_out) begin
      #1;
      pcim_bready_i = bp_on ? (($urandom % 4) != 0) : 1'b1;
      pcim_rready_i = hold_r ? 1'b0 : (bp_on ? (($urandom % 3) != 0) : 1'b1);
   end

   // ------------------------------------------------------------
   // bus tasks, each ends 1 ns after a rising edge
   // ------------------------------------------------------------
   task automatic write_burst(input logic [4:0] id, input logic [7:0] idx, input int beats,
                              input logic rand_strb, input logic [7:0] strb,
                              input logic [63:0] seed_word);
      logic ok;
      logic [7:0] a;
      pcim_awid_i    = id;
      pcim_awaddr_i  = 32'(idx) << 3;
      pcim_awvalid_i = 1'b1;
      do begin
         @(negedge clk_out) ok = pcim_awready_o;
         @(posedge clk_out) #1;
      end while (!ok);
      pcim_awvalid_i = 1'b0;
      for (int b = 0; b < beats; b++) begin
         a             = 8'(int'(idx) + b);
         pcim_wdata_i  = seed_word ^ {24'(a) * 24'd7, 8'hA5, ~32'(a)};
         pcim_wstrb_i  = rand_strb ? 8'($urandom) : strb;
         pcim_wlast_i  = (b == beats - 1);
         pcim_wvalid_i = 1'b1;
         do begin
            @(negedge clk_out) ok = pcim_wready_o;
            @(posedge clk_out) #1;
         end while (!ok);
      end
      pcim_wvalid_i = 1'b0;
      pcim_wlast_i  = 1'b0;
      do begin
         @(negedge clk_out) ok = pcim_bvalid_o && pcim_bready_i;
         @(posedge clk_out) #1;
      end while (!ok);
   endtask

   task automatic read_cmd(input logic [4:0] id, input logic [7:0] idx, input logic [7:0] len);
      logic ok;
      pcim_arid_i    = id;
      pcim_araddr_i  = 32'(idx) << 3;
      pcim_arlen_i   = len;
      pcim_arvalid_i = 1'b1;
      do begin
         @(negedge clk_out) ok = pcim_arready_o;
         @(posedge clk_out) #1;
      end while (!ok);
      pcim_arvalid_i = 1'b0;
   endtask

   task automatic wait_reads_done();
      while (pending_rd != 0) @(negedge clk_out);
      @(posedge clk_out) #1;
   endtask

   task automatic end_test(input string name);
      int errs;
      if (pending_rd != 0 || pending_wr != 0) begin
         tb_errors++;
         $display("commands left without responses at end of %s", name);
      end
      errs = error_count + tb_errors - mark;
      tests_run++;
      if (errs != 0) tests_failed++;
      $display("test %0d %s: %s (%0d errors)", tests_run, name, errs == 0 ? "ok" : "bad", errs);
      mark = error_count + tb_errors;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout after %0d ns, the DUT stopped answering", WATCHDOG_NS);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(SEED));
      {pcim_awid_i, pcim_awaddr_i, pcim_awvalid_i, pcim_wdata_i, pcim_wstrb_i} = '0;
      {pcim_wlast_i, pcim_wvalid_i, pcim_arid_i, pcim_araddr_i, pcim_arlen_i} = '0;
      pcim_arvalid_i = 1'b0;
      pcim_bready_i  = 1'b1;
      pcim_rready_i  = 1'b1;
      sync_rst_n     = 1'b0;
      mark           = 0;
      repeat (3) @(posedge clk_out);
      #1 sync_rst_n = 1'b1;
      repeat (2) @(posedge clk_out);
      #1 end_test("reset values");

      for (int i = 0; i < 32; i++) begin   // known contents everywhere
         write_burst(5'(i), 8'(i * 8), 8, 1'b0, 8'hFF, 64'h0);
      end

      write_burst(5'd3, 8'd20, 1, 1'b0, 8'hFF, 64'h1122_3344_5566_7788);
      read_cmd(5'd4, 8'd20, 8'd0);
      wait_reads_done();
      end_test("single beat");

      write_burst(5'd5, 8'd40, 1, 1'b0, 8'hFF, 64'hDEAD_BEEF_0BAD_F00D);
      write_burst(5'd6, 8'd40, 1, 1'b0, 8'h5A, 64'h0123_4567_89AB_CDEF);
      read_cmd(5'd7, 8'd40, 8'd0);
      wait_reads_done();
      end_test("partial strobes");

      write_burst(5'd8, 8'd100, 4, 1'b0, 8'hFF, 64'hCAFE_0000_0000_0001);
      read_cmd(5'd9, 8'd100, 8'd3);
      write_burst(5'd10, 8'd254, 4, 1'b0, 8'hFF, 64'h0000_FACE_0000_0002);
      read_cmd(5'd11, 8'd254, 8'd3);
      wait_reads_done();
      end_test("bursts and wrap");

      bp_on = 1'b1;
      for (int i = 0; i < 3; i++) begin
         write_burst(5'(12 + i), 8'($urandom), 1 + int'($urandom % 4), 1'b1, 8'h0, 64'h77);
      end
      hold_r     = 1'b1;
      stall_base = ar_stall;
      for (int i = 0; i < 4; i++) begin
         read_cmd(5'(16 + i), 8'($urandom), 8'($urandom % 4));
      end
      repeat (6) @(posedge clk_out);
      #1 hold_r = 1'b0;
      read_cmd(5'd20, 8'($urandom), 8'd2);
      read_cmd(5'd21, 8'($urandom), 8'd1);
      wait_reads_done();
      if (ar_stall == stall_base) begin
         tb_errors++;
         $display("arready never fell with the read queue full");
      end
      end_test("back-pressure");

      for (int i = 0; i < NUM_RANDOM; i++) begin
         if ($urandom % 2 == 0) begin
            write_burst(5'($urandom), 8'($urandom), 1 + int'($urandom % MAX_BEATS), 1'b1,
                        8'h0, {$urandom, $urandom});
         end else begin
            read_cmd(5'($urandom), 8'($urandom), 8'($urandom % MAX_BEATS));
            wait_reads_done();
         end
      end
      end_test("random traffic");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
               tests_failed, check_count, error_count + tb_errors);
      if (error_count + tb_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
